// ==== src.f ====
+incdir+verilog
verilog/uart_pkg.sv
verilog/uart_tx.sv
verilog/uart_rx.sv
verilog/secded_decoder.sv
verilog/uart_ecc_link.sv
test/uart_ecc_link_assert.sv
test/uart_ecc_link_tb.sv

// ==== test/uart_ecc_link_assert.sv ====
// Handshake and reset assertions for the link top level, attached to it with bind
`default_nettype none

module uart_ecc_link_assert (
    input logic                 clk,
    input logic                 reset,
    input logic                 tx_req,
    input logic                 tx_ack,
    input logic                 tx,
    input logic                 rx_req,
    input logic                 rx_ack,
    input logic [3:0]           rx_nibble,
    input uart_pkg::rx_status_t rx_status
);

    int   fail_count = 0;   // Failed assertion count
    logic tx_started;       // A frame was accepted since reset

    always @(posedge clk) begin
        if (reset) begin
            tx_started <= 1'b0;
        end else if (tx_ack) begin
            tx_started <= 1'b1;
        end
    end

    ack_after_req: assert property (@(posedge clk) disable iff (reset)
        $rose(tx_ack) |-> $past(tx_req))
        else begin
            fail_count++;
            $error("tx_ack rose without tx_req");
        end

    req_until_ack: assert property (@(posedge clk) disable iff (reset)
        rx_req && !rx_ack |=> rx_req)
        else begin
            fail_count++;
            $error("rx_req fell before rx_ack");
        end

    data_stable: assert property (@(posedge clk) disable iff (reset)
        rx_req && $past(rx_req) |-> $stable(rx_nibble) && $stable(rx_status))
        else begin
            fail_count++;
            $error("rx_nibble or rx_status changed while rx_req was high");
        end

    idle_high: assert property (@(posedge clk) disable iff (reset)
        !tx_started |-> tx)
        else begin
            fail_count++;
            $error("tx left the idle level before any frame was accepted");
        end

endmodule

bind uart_ecc_link uart_ecc_link_assert u_link_assert (
    .clk       (clk),
    .reset     (reset),
    .tx_req    (tx_req),
    .tx_ack    (tx_ack),
    .tx        (tx),
    .rx_req    (rx_req),
    .rx_ack    (rx_ack),
    .rx_nibble (rx_nibble),
    .rx_status (rx_status)
);

`default_nettype wire

// ==== test/uart_ecc_link_tb.sv ====
// Testbench for the ECC serial link, runs table and random frames and checks them against SECDED rules
`default_nettype none
`include "uart_settings.svh"

module uart_ecc_link_tb;

    localparam int n_random   = 8;
    localparam int bit_clks   = `UART_CLKS_PER_BIT;
    localparam int wait_limit = 12 * bit_clks * 4;   // Cycles allowed per handshake phase
    localparam int sel_tx_ack = 0;
    localparam int sel_rx_req = 1;

    logic                 clk = 1'b0;
    logic                 reset;
    logic                 tx_req;
    logic [3:0]           tx_nibble;
    logic                 tx_ack;
    logic                 tx;
    logic                 rx;
    logic                 rx_req;
    logic [3:0]           rx_nibble;
    uart_pkg::rx_status_t rx_status;
    logic                 rx_ack;
    logic                 rx_overrun;
    logic                 loopback;
    logic                 table_ready = 1'b0;
    logic [31:0]          seed;
    int                   value_errors = 0;
    int                   timeouts = 0;
    int                   overrun_pulses = 0;

    // Stimulus table, one entry per index
    logic [3:0]           tab_nibble[$];
    logic [7:0]           tab_mask[$];     // Bits flipped in the encoded byte
    logic                 tab_flip[$];     // Flip the UART parity bit
    logic                 tab_hold[$];     // Withhold ack and send a frame to be dropped
    logic [3:0]           tab_exp_nib[$];
    uart_pkg::rx_status_t tab_exp_stat[$];

    uart_ecc_link u_uart_ecc_link (
        .clk        (clk),
        .reset      (reset),
        .tx_req     (tx_req),
        .tx_nibble  (tx_nibble),
        .tx_ack     (tx_ack),
        .tx         (tx),
        .rx         (rx),
        .rx_req     (rx_req),
        .rx_nibble  (rx_nibble),
        .rx_status  (rx_status),
        .rx_ack     (rx_ack),
        .rx_overrun (rx_overrun)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        if (loopback) begin
            rx <= tx;   // Line closed from tx back to rx
        end
    end

    always @(negedge clk) begin
        if (rx_overrun === 1'b1) begin
            overrun_pulses <= overrun_pulses + 1;
        end
    end

    task automatic add_entry(input logic [3:0] nib, input logic [7:0] mask, input logic flip,
                             input logic hold, input logic [3:0] exp_nib,
                             input uart_pkg::rx_status_t exp_stat);
        tab_nibble.push_back(nib);
        tab_mask.push_back(mask);
        tab_flip.push_back(flip);
        tab_hold.push_back(hold);
        tab_exp_nib.push_back(exp_nib);
        tab_exp_stat.push_back(exp_stat);
    endtask

    // Check bit k covers every Hamming position with bit k set
    function automatic uart_pkg::secded_byte_t encode_nibble(input logic [3:0] nib);
        logic [7:1]             pos;
        logic                   c;
        uart_pkg::secded_byte_t b;
        pos = '0;
        pos[3] = nib[0];
        pos[5] = nib[1];
        pos[6] = nib[2];
        pos[7] = nib[3];
        for (int k = 0; k < 3; k++) begin
            c = 1'b0;
            for (int p = 3; p <= 7; p++) begin
                if (p[k]) begin
                    c = c ^ pos[p];
                end
            end
            pos[1 << k] = c;
        end
        b.raw = {^pos, pos};   // Overall parity on top
        return b;
    endfunction

    function automatic logic uart_parity(input logic [7:0] data);
        return (^data) ^ (`UART_PARITY_ODD != 0);
    endfunction

    task automatic check_byte(input uart_pkg::secded_byte_t got, input uart_pkg::secded_byte_t exp,
                              input string what);
        if (got !== exp) begin
            value_errors++;
            $display("[ERROR] %0t: %s byte is %h, expected %h", $time, what, got.raw, exp.raw);
        end
    endtask

    task automatic check_status(input uart_pkg::rx_status_t got, input uart_pkg::rx_status_t exp,
                                input string what);
        if (got !== exp) begin
            value_errors++;
            $display("[ERROR] %0t: %s is %s, expected %s", $time, what, got.name(), exp.name());
        end
    endtask

    task automatic check_nibble(input logic [3:0] got, input logic [3:0] exp, input string what);
        if (got !== exp) begin
            value_errors++;
            $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            value_errors++;
            $display("[ERROR] %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic wait_level(input int sel, input logic level, input string what);
        int   n;
        logic v;
        n = 0;
        v = ~level;
        while (v !== level && n < wait_limit) begin
            @(negedge clk);
            v = (sel == sel_tx_ack) ? tx_ack : rx_req;
            n++;
        end
        if (v !== level) begin
            timeouts++;
            $display("Timeout: the %s handshake never completed at time %0t", what, $time);
        end
    endtask

    task automatic send_nibble(input logic [3:0] nib);
        @(posedge clk);
        tx_req    <= 1'b1;
        tx_nibble <= nib;
        wait_level(sel_tx_ack, 1'b1, "send");
        @(posedge clk);
        tx_req <= 1'b0;
        wait_level(sel_tx_ack, 1'b0, "send");
    endtask

    task automatic capture_frame(output uart_pkg::secded_byte_t data, output logic start_b,
                                 output logic par_b, output logic stop_b);
        logic [9:0] bits;
        int         n;
        n = 0;
        bits = 'x;
        start_b = 1'bx;
        while (tx !== 1'b0 && n < wait_limit) begin
            @(negedge clk);
            n++;
        end
        if (tx !== 1'b0) begin
            timeouts++;
            $display("Timeout: no start bit appeared on tx at time %0t", $time);
        end else begin
            repeat (bit_clks / 2) @(negedge clk);   // Middle of the start bit
            start_b = tx;
            for (int i = 0; i < 10; i++) begin
                repeat (bit_clks) @(negedge clk);
                bits[i] = tx;
            end
        end
        data.raw = bits[7:0];
        par_b = bits[8];
        stop_b = bits[9];
    endtask

    task automatic drive_frame(input logic [7:0] data, input logic par_b);
        logic [10:0] bits;
        bits = {1'b1, par_b, data, 1'b0};   // Stop, parity, data, start
        for (int i = 0; i < 11; i++) begin
            @(posedge clk);
            rx <= bits[i];
            repeat (bit_clks - 1) @(posedge clk);
        end
    endtask

    task automatic release_rx;
        @(posedge clk);
        rx_ack <= 1'b1;
        wait_level(sel_rx_req, 1'b0, "receive");
        @(posedge clk);
        rx_ack <= 1'b0;
    endtask

    task automatic run_entry(input int idx);
        uart_pkg::secded_byte_t exp_b;
        uart_pkg::secded_byte_t got_b;
        uart_pkg::secded_byte_t drop_b;
        logic                   got_start;
        logic                   got_par;
        logic                   got_stop;
        int                     pulses;
        exp_b = encode_nibble(tab_nibble[idx]);
        fork
            send_nibble(tab_nibble[idx]);
            capture_frame(got_b, got_start, got_par, got_stop);
        join
        check_bit("tx start bit", got_start, 1'b0);
        check_byte(got_b, exp_b, "tx frame");
        check_bit("tx parity bit", got_par, uart_parity(exp_b.raw));
        check_bit("tx stop bit", got_stop, 1'b1);
        pulses = overrun_pulses;
        drive_frame(exp_b.raw ^ tab_mask[idx], uart_parity(exp_b.raw) ^ tab_flip[idx]);
        wait_level(sel_rx_req, 1'b1, "receive");
        check_nibble(rx_nibble, tab_exp_nib[idx], "rx_nibble");
        check_status(rx_status, tab_exp_stat[idx], "rx_status");
        check_bit("rx_overrun seen", overrun_pulses != pulses, 1'b0);
        if (tab_hold[idx]) begin
            pulses = overrun_pulses;
            drop_b = encode_nibble(~tab_nibble[idx]);
            drive_frame(drop_b.raw, uart_parity(drop_b.raw));   // Arrives while req is open
            @(negedge clk);
            check_bit("single rx_overrun pulse", overrun_pulses - pulses == 1, 1'b1);
            check_bit("rx_req held", rx_req, 1'b1);
            check_nibble(rx_nibble, tab_exp_nib[idx], "held rx_nibble");
            check_status(rx_status, tab_exp_stat[idx], "held rx_status");
        end
        release_rx();
    endtask

    task automatic run_random;
        uart_pkg::secded_byte_t exp_b;
        uart_pkg::secded_byte_t got_b;
        logic [3:0]             nib;
        logic                   got_start;
        logic                   got_par;
        logic                   got_stop;
        nib = 4'($urandom());
        exp_b = encode_nibble(nib);
        fork
            send_nibble(nib);
            capture_frame(got_b, got_start, got_par, got_stop);
        join
        check_byte(got_b, exp_b, "looped tx frame");
        wait_level(sel_rx_req, 1'b1, "receive");
        check_nibble(rx_nibble, nib, "looped rx_nibble");
        check_status(rx_status, uart_pkg::ok, "looped rx_status");
        release_rx();
    endtask

    initial begin
        reset     = 1'b1;
        tx_req    = 1'b0;
        tx_nibble = 4'd0;
        rx        = 1'b1;
        rx_ack    = 1'b0;
        loopback  = 1'b0;
        seed      = 32'hfc6c;
        void'($urandom(seed));
        for (int n = 0; n < 16; n++) begin
            add_entry(4'(n), 8'h00, 1'b0, 1'b0, 4'(n), uart_pkg::ok);
        end
        for (int k = 0; k < 8; k++) begin
            add_entry(4'(k * 3 + 1), 8'(1 << k), 1'b0, 1'b0, 4'(k * 3 + 1), uart_pkg::corrected);
        end
        add_entry(4'h6, 8'h03, 1'b0, 1'b0, 4'h6, uart_pkg::uncorrectable);   // Two check bits
        add_entry(4'h9, 8'h84, 1'b0, 1'b0, 4'h8, uart_pkg::uncorrectable);   // p0 and d1
        add_entry(4'h3, 8'h30, 1'b0, 1'b0, 4'h5, uart_pkg::uncorrectable);   // d2 and d3
        add_entry(4'hc, 8'h00, 1'b1, 1'b0, 4'hc, uart_pkg::parity_err);
        add_entry(4'h5, 8'h41, 1'b1, 1'b0, 4'hd, uart_pkg::uncorrectable);   // Beats parity_err
        add_entry(4'h7, 8'h00, 1'b0, 1'b1, 4'h7, uart_pkg::ok);
        add_entry(4'h2, 8'h00, 1'b0, 1'b0, 4'h2, uart_pkg::ok);              // Right after overrun
        table_ready = 1'b1;
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        repeat (2) @(posedge clk);
        for (int i = 0; i < tab_nibble.size(); i++) begin
            run_entry(i);
        end
        @(posedge clk);
        loopback <= 1'b1;
        for (int r = 0; r < n_random; r++) begin
            run_random();
        end
        repeat (4) @(posedge clk);
        $display("Summary: %0d value errors, %0d timeouts, %0d assertion failures",
                 value_errors, timeouts, u_uart_ecc_link.u_link_assert.fail_count);
        if (value_errors == 0 && timeouts == 0 && u_uart_ecc_link.u_link_assert.fail_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // Each entry needs roughly two frames, the margin covers reset and the dropped frame
    initial begin
        longint limit;
        wait (table_ready);
        limit = longint'(tab_nibble.size() + n_random + 4) * 12 * bit_clks * 20 * 2;
        #(limit);
        $display("Watchdog: tests still running after %0d time units", limit);
        $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/secded_decoder.sv ====
// SECDED decode of received bytes and the host receive handshake with overrun flag
`default_nettype none

module secded_decoder (
    input  logic                   clk,
    input  logic                   reset,
    input  uart_pkg::secded_byte_t rx_byte,
    input  logic                   rx_parity_bad,
    input  logic                   rx_done,
    output logic                   rx_req,
    input  logic                   rx_ack,
    output logic [3:0]             rx_nibble,
    output uart_pkg::rx_status_t   rx_status,
    output logic                   rx_overrun
);

    logic [2:0]             syndrome;
    logic                   overall_bad;
    logic [7:0]             flip_mask;
    logic                   accept;
    uart_pkg::secded_byte_t fixed_byte;
    uart_pkg::rx_status_t   status_next;

    // Recomputed checks, bit n covers the positions with bit n set
    assign syndrome[0] = rx_byte.code.p1 ^ rx_byte.code.d1 ^ rx_byte.code.d2 ^ rx_byte.code.d4;
    assign syndrome[1] = rx_byte.code.p2 ^ rx_byte.code.d1 ^ rx_byte.code.d3 ^ rx_byte.code.d4;
    assign syndrome[2] = rx_byte.code.p3 ^ rx_byte.code.d2 ^ rx_byte.code.d3 ^ rx_byte.code.d4;
    assign overall_bad = ^rx_byte.raw;

    always_comb begin
        flip_mask = 8'd0;
        if (overall_bad && syndrome != 3'd0) begin
            flip_mask[syndrome - 3'd1] = 1'b1;   // Position n sits at raw bit n-1
        end
        fixed_byte.raw = rx_byte.raw ^ flip_mask;
    end

    always_comb begin
        if (syndrome != 3'd0 && !overall_bad) begin
            status_next = uart_pkg::uncorrectable;
        end else if (overall_bad) begin
            status_next = uart_pkg::corrected;   // Includes a flipped p0
        end else if (rx_parity_bad) begin
            status_next = uart_pkg::parity_err;
        end else begin
            status_next = uart_pkg::ok;
        end
    end

    // New byte only while the previous handshake is fully closed
    assign accept = rx_done && !rx_req && !rx_ack;

    always_ff @(posedge clk) begin
        if (reset) begin
            rx_req     <= 1'b0;
            rx_overrun <= 1'b0;
        end else begin
            rx_overrun <= rx_done && !accept;   // Byte dropped
            if (accept) begin
                rx_req    <= 1'b1;
                rx_nibble <= {fixed_byte.code.d4, fixed_byte.code.d3,
                              fixed_byte.code.d2, fixed_byte.code.d1};
                rx_status <= status_next;
            end else if (rx_req && rx_ack) begin
                rx_req <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/uart_ecc_link.sv ====
// Top of the ECC serial link endpoint, connecting transmitter, receiver and SECDED decoder
`default_nettype none

module uart_ecc_link (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 tx_req,
    input  logic [3:0]           tx_nibble,
    output logic                 tx_ack,
    output logic                 tx,
    input  logic                 rx,
    output logic                 rx_req,
    output logic [3:0]           rx_nibble,
    output uart_pkg::rx_status_t rx_status,
    input  logic                 rx_ack,
    output logic                 rx_overrun
);

    uart_pkg::secded_byte_t rx_byte;         // Raw received code byte
    logic                   rx_parity_bad;
    logic                   rx_done;

    uart_tx u_uart_tx (
        .clk       (clk),
        .reset     (reset),
        .tx_req    (tx_req),
        .tx_nibble (tx_nibble),
        .tx_ack    (tx_ack),
        .tx        (tx)
    );

    uart_rx u_uart_rx (
        .clk           (clk),
        .reset         (reset),
        .rx            (rx),
        .rx_byte       (rx_byte),
        .rx_parity_bad (rx_parity_bad),
        .rx_done       (rx_done)
    );

    secded_decoder u_secded_decoder (
        .clk           (clk),
        .reset         (reset),
        .rx_byte       (rx_byte),
        .rx_parity_bad (rx_parity_bad),
        .rx_done       (rx_done),
        .rx_req        (rx_req),
        .rx_ack        (rx_ack),
        .rx_nibble     (rx_nibble),
        .rx_status     (rx_status),
        .rx_overrun    (rx_overrun)
    );

endmodule

`default_nettype wire

// ==== verilog/uart_pkg.sv ====
// Shared types of the ECC serial link, referenced by scoped name from the RTL and testbench
`default_nettype none

package uart_pkg;

    // Hamming(7,4) positions 7 down to 1 with the overall parity on top
    typedef struct packed {
        logic p0;   // Overall parity
        logic d4;   // Position 7
        logic d3;   // Position 6
        logic d2;   // Position 5
        logic p3;   // Position 4
        logic d1;   // Position 3
        logic p2;   // Position 2
        logic p1;   // Position 1
    } secded_code_t;

    // One byte seen either as wire bits or as named code fields
    typedef union packed {
        logic [7:0]   raw;    // Byte as it travels on the line
        secded_code_t code;   // Same byte split into check and data bits
    } secded_byte_t;

    // Result attached to every delivered nibble
    typedef enum logic [1:0] {
        ok            = 2'd0,   // Nothing wrong
        corrected     = 2'd1,   // Single flipped bit fixed
        uncorrectable = 2'd2,   // Double error, nibble passed as is
        parity_err    = 2'd3    // Code clean but UART parity wrong
    } rx_status_t;

endpackage

`default_nettype wire

// ==== verilog/uart_rx.sv ====
// Receive side of the link: finds the start bit, votes each bit over its period, checks parity
`default_nettype none
`include "uart_settings.svh"

module uart_rx (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   rx,
    output uart_pkg::secded_byte_t rx_byte,
    output logic                   rx_parity_bad,
    output logic                   rx_done
);

    localparam logic [2:0] st_idle  = 3'd0;
    localparam logic [2:0] st_check = 3'd1;
    localparam logic [2:0] st_start = 3'd2;
    localparam logic [2:0] st_recv  = 3'd3;
    localparam logic [2:0] st_done  = 3'd4;

    localparam logic [`UART_CNT_W-1:0] bit_last = `UART_CLKS_PER_BIT - 1;

    logic [2:0]             state;
    logic [`UART_CNT_W-1:0] clk_cnt;
    logic [`UART_CNT_W-1:0] zero_cnt;
    logic [`UART_CNT_W-1:0] one_cnt;
    logic [`UART_CNT_W-1:0] zero_next;
    logic [`UART_CNT_W-1:0] one_next;
    logic [3:0]             bit_idx;     // 8 data bits then parity
    logic [8:0]             shift_reg;   // Parity on top, data below
    logic [8:0]             frame_next;
    logic                   vote;
    logic                   bit_end;

    // Counts including the current sample so the last one still votes
    assign one_next   = one_cnt + {{(`UART_CNT_W-1){1'b0}}, rx};
    assign zero_next  = zero_cnt + {{(`UART_CNT_W-1){1'b0}}, ~rx};
    assign vote       = (one_next >= zero_next);   // Tie goes to the idle level
    assign bit_end    = (clk_cnt == bit_last);
    assign frame_next = {vote, shift_reg[8:1]};

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= st_idle;
            clk_cnt  <= '0;
            zero_cnt <= '0;
            one_cnt  <= '0;
            bit_idx  <= '0;
            rx_done  <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (!rx) begin
                        clk_cnt <= {{(`UART_CNT_W-1){1'b0}}, 1'b1};   // Edge cycle counts
                        state   <= st_check;
                    end
                end
                st_check: begin
                    if (rx) begin
                        state <= st_idle;   // Glitch, not a start bit
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                        state   <= st_start;
                    end
                end
                st_start: begin
                    if (bit_end) begin
                        clk_cnt  <= '0;
                        zero_cnt <= '0;
                        one_cnt  <= '0;
                        bit_idx  <= '0;
                        state    <= st_recv;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                st_recv: begin
                    if (bit_end) begin
                        clk_cnt   <= '0;
                        zero_cnt  <= '0;
                        one_cnt   <= '0;
                        shift_reg <= frame_next;
                        bit_idx   <= bit_idx + 1'b1;
                        if (bit_idx == 4'd8) begin
                            rx_byte.raw   <= frame_next[7:0];
                            rx_parity_bad <= (^frame_next) ^ (`UART_PARITY_ODD != 0);
                            rx_done       <= 1'b1;
                            state         <= st_done;
                        end
                    end else begin
                        clk_cnt  <= clk_cnt + 1'b1;
                        zero_cnt <= zero_next;
                        one_cnt  <= one_next;
                    end
                end
                st_done: begin
                    rx_done <= 1'b0;
                    if (rx) begin
                        state <= st_idle;   // Stop level reached
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== verilog/uart_settings.svh ====
// Bit timing and UART parity macros shared by the serial modules and the testbench
`ifndef UART_SETTINGS_SVH
`define UART_SETTINGS_SVH

// Clock cycles per serial bit, even and at least 4
`define UART_CLKS_PER_BIT 16

// UART parity sense, 0 for even and 1 for odd
`define UART_PARITY_ODD 0

// Width of the bit period and vote counters
`define UART_CNT_W 6

`endif

// ==== verilog/uart_tx.sv ====
// Send side of the link: takes a nibble over req/ack, SECDED encodes it and shifts out the frame
`default_nettype none
`include "uart_settings.svh"

module uart_tx (
    input  logic       clk,
    input  logic       reset,
    input  logic       tx_req,
    input  logic [3:0] tx_nibble,
    output logic       tx_ack,
    output logic       tx
);

    localparam logic [2:0] st_idle    = 3'd0;
    localparam logic [2:0] st_start   = 3'd1;
    localparam logic [2:0] st_data    = 3'd2;
    localparam logic [2:0] st_parity  = 3'd3;
    localparam logic [2:0] st_stop    = 3'd4;
    localparam logic [2:0] st_release = 3'd5;

    localparam logic [`UART_CNT_W-1:0] bit_last = `UART_CLKS_PER_BIT - 1;

    logic [2:0]             state;
    logic [`UART_CNT_W-1:0] clk_cnt;
    logic [2:0]             bit_idx;
    logic                   bit_end;
    logic                   parity_bit;
    uart_pkg::secded_byte_t enc_byte;
    uart_pkg::secded_byte_t tx_byte;   // Frame payload held for the whole frame

    // Hamming(7,4) plus overall parity, built through the field view
    always_comb begin
        enc_byte.code.d1 = tx_nibble[0];
        enc_byte.code.d2 = tx_nibble[1];
        enc_byte.code.d3 = tx_nibble[2];
        enc_byte.code.d4 = tx_nibble[3];
        enc_byte.code.p1 = tx_nibble[0] ^ tx_nibble[1] ^ tx_nibble[3];
        enc_byte.code.p2 = tx_nibble[0] ^ tx_nibble[2] ^ tx_nibble[3];
        enc_byte.code.p3 = tx_nibble[1] ^ tx_nibble[2] ^ tx_nibble[3];
        enc_byte.code.p0 = ^enc_byte.raw[6:0];   // Makes all eight bits even
    end

    assign bit_end    = (clk_cnt == bit_last);
    assign parity_bit = (^tx_byte.raw) ^ (`UART_PARITY_ODD != 0);

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= st_idle;
            clk_cnt <= '0;
            bit_idx <= '0;
            tx_ack  <= 1'b0;
            tx      <= 1'b1;
        end else begin
            if (tx_ack && !tx_req) begin
                tx_ack <= 1'b0;   // Host let go, close the handshake
            end
            case (state)
                st_idle: begin
                    tx <= 1'b1;
                    if (tx_req && !tx_ack) begin
                        tx_byte <= enc_byte;
                        tx_ack  <= 1'b1;
                        clk_cnt <= '0;
                        state   <= st_start;
                    end
                end
                st_start: begin
                    tx      <= 1'b0;
                    clk_cnt <= bit_end ? '0 : clk_cnt + 1'b1;
                    if (bit_end) begin
                        bit_idx <= '0;
                        state   <= st_data;
                    end
                end
                st_data: begin
                    tx      <= tx_byte.raw[bit_idx];   // LSB first
                    clk_cnt <= bit_end ? '0 : clk_cnt + 1'b1;
                    if (bit_end) begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= st_parity;
                        end
                    end
                end
                st_parity: begin
                    tx      <= parity_bit;
                    clk_cnt <= bit_end ? '0 : clk_cnt + 1'b1;
                    if (bit_end) begin
                        state <= st_stop;
                    end
                end
                st_stop: begin
                    tx      <= 1'b1;
                    clk_cnt <= bit_end ? '0 : clk_cnt + 1'b1;
                    if (bit_end) begin
                        state <= st_release;
                    end
                end
                st_release: begin
                    tx <= 1'b1;
                    if (!tx_ack) begin
                        state <= st_idle;   // Request seen low, ready for the next nibble
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

`default_nettype wire
